// ==== Bender.yml ====
package:
  name: ex_mem_slice

sources:
  # Package first, then the stages, then the top level.
  - logic/rv_pipe_pkg.sv
  - logic/execute_stage.sv
  - logic/ex_mem_reg.sv
  - logic/memory_stage.sv
  - logic/ex_mem_slice.sv

  - target: test
    files:
      - testbench/ex_mem_slice_asserts.sv
      - testbench/ex_mem_slice_tb.sv

// ==== files.f ====
logic/rv_pipe_pkg.sv
logic/execute_stage.sv
logic/ex_mem_reg.sv
logic/memory_stage.sv
logic/ex_mem_slice.sv
testbench/ex_mem_slice_asserts.sv
testbench/ex_mem_slice_tb.sv

// ==== logic/ex_mem_reg.sv ====
`timescale 1ns/10ps

module ex_mem_reg (
    input  logic                  clk,
    input  logic                  clear,
    input  rv_pipe_pkg::ex_mem_t  ex_bundle,
    output rv_pipe_pkg::ex_mem_t  ex_mem
);

    // Whole bundle zeroed, so a cleared stage is a bubble.
    always_ff @(posedge clk or posedge clear) begin
        if (clear) begin
            ex_mem <= '0;
        end else begin
            ex_mem <= ex_bundle;
        end
    end

endmodule

// ==== logic/ex_mem_slice.sv ====
`timescale 1ns/10ps

module ex_mem_slice (
    input  logic                   clk,
    input  logic                   clear,
    input  rv_pipe_pkg::id_ex_t    id_ex,
    output rv_pipe_pkg::wb_t       wb,
    output rv_pipe_pkg::redirect_t redirect
);

    rv_pipe_pkg::ex_mem_t ex_bundle;
    rv_pipe_pkg::ex_mem_t ex_mem;

    execute_stage u_execute (
        .id_ex     (id_ex),
        .ex_bundle (ex_bundle)
    );

    // Single pipeline boundary between execute and memory.
    ex_mem_reg u_ex_mem_reg (
        .clk       (clk),
        .clear     (clear),
        .ex_bundle (ex_bundle),
        .ex_mem    (ex_mem)
    );

    memory_stage u_memory (
        .clk      (clk),
        .ex_mem   (ex_mem),
        .wb       (wb),
        .redirect (redirect)
    );

endmodule

// ==== logic/execute_stage.sv ====
`timescale 1ns/10ps

module execute_stage (
    input  rv_pipe_pkg::id_ex_t   id_ex,
    output rv_pipe_pkg::ex_mem_t  ex_bundle
);

    logic [rv_pipe_pkg::xlen-1:0] op_a;
    logic [rv_pipe_pkg::xlen-1:0] op_b;
    logic [4:0] shamt;
    logic [rv_pipe_pkg::xlen-1:0] alu_result;
    logic [rv_pipe_pkg::xlen-1:0] ex_result;
    logic alu_lt;
    logic alu_ltu;
    logic br_eq;
    logic br_lt;
    logic br_ltu;
    logic cond_true;

    assign op_a = id_ex.rs1_data;
    assign op_b = id_ex.alu_src_imm ? id_ex.imm : id_ex.rs2_data;
    assign shamt = op_b[4:0];

    // Set-less-than works on the selected second operand.
    assign alu_lt = $signed(op_a) < $signed(op_b);
    assign alu_ltu = op_a < op_b;

    always_comb begin
        case (id_ex.alu_op)
            rv_pipe_pkg::alu_add:  alu_result = op_a + op_b;
            rv_pipe_pkg::alu_sub:  alu_result = op_a - op_b;
            rv_pipe_pkg::alu_sll:  alu_result = op_a << shamt;
            rv_pipe_pkg::alu_slt:  alu_result = {{(rv_pipe_pkg::xlen-1){1'b0}}, alu_lt};
            rv_pipe_pkg::alu_sltu: alu_result = {{(rv_pipe_pkg::xlen-1){1'b0}}, alu_ltu};
            rv_pipe_pkg::alu_xor:  alu_result = op_a ^ op_b;
            rv_pipe_pkg::alu_srl:  alu_result = op_a >> shamt;
            rv_pipe_pkg::alu_sra:  alu_result = $signed(op_a) >>> shamt;
            rv_pipe_pkg::alu_or:   alu_result = op_a | op_b;
            rv_pipe_pkg::alu_and:  alu_result = op_a & op_b;
            default:               alu_result = '0;
        endcase
    end

    always_comb begin
        case (id_ex.result_sel)
            rv_pipe_pkg::res_auipc: ex_result = id_ex.pc + id_ex.imm;
            rv_pipe_pkg::res_lui:   ex_result = id_ex.imm;
            default:                ex_result = alu_result;
        endcase
    end

    // Branch compare always uses both registers.
    assign br_eq = id_ex.rs1_data == id_ex.rs2_data;
    assign br_lt = $signed(id_ex.rs1_data) < $signed(id_ex.rs2_data);
    assign br_ltu = id_ex.rs1_data < id_ex.rs2_data;

    always_comb begin
        case (id_ex.funct3)
            rv_pipe_pkg::f3_beq:  cond_true = br_eq;
            rv_pipe_pkg::f3_bne:  cond_true = !br_eq;
            rv_pipe_pkg::f3_blt:  cond_true = br_lt;
            rv_pipe_pkg::f3_bge:  cond_true = !br_lt;
            rv_pipe_pkg::f3_bltu: cond_true = br_ltu;
            rv_pipe_pkg::f3_bgeu: cond_true = !br_ltu;
            default:              cond_true = 1'b0;
        endcase
    end

    always_comb begin
        ex_bundle.valid = id_ex.valid;
        ex_bundle.branch = id_ex.branch;
        ex_bundle.reg_write = id_ex.reg_write;
        ex_bundle.mem_read = id_ex.mem_read;
        ex_bundle.mem_write = id_ex.mem_write;
        ex_bundle.wb_sel = id_ex.wb_sel;
        ex_bundle.funct3 = id_ex.funct3;
        ex_bundle.rd = id_ex.rd;
        ex_bundle.result = ex_result;
        ex_bundle.cond_true = cond_true;
        ex_bundle.store_data = id_ex.rs2_data;
        ex_bundle.branch_target = id_ex.pc + id_ex.imm;
        // Return address for jumps.
        ex_bundle.link = id_ex.pc + 32'd4;
    end

endmodule

// ==== logic/memory_stage.sv ====
`timescale 1ns/10ps

module memory_stage (
    input  logic                   clk,
    input  rv_pipe_pkg::ex_mem_t   ex_mem,
    output rv_pipe_pkg::wb_t       wb,
    output rv_pipe_pkg::redirect_t redirect
);

    rv_pipe_pkg::mem_word_u mem [rv_pipe_pkg::mem_words];

    logic [rv_pipe_pkg::mem_addr_bits-1:0] word_idx;
    logic [1:0] offset;
    rv_pipe_pkg::mem_word_u rd_word;
    rv_pipe_pkg::mem_word_u wr_word;
    logic [3:0] lane_mask;
    logic store_en;
    logic [7:0] byte_sel;
    logic [15:0] half_sel;
    logic [rv_pipe_pkg::xlen-1:0] load_data;

    assign word_idx = ex_mem.result[rv_pipe_pkg::mem_addr_bits+1:2];
    assign offset = ex_mem.result[1:0];
    assign store_en = ex_mem.valid && ex_mem.mem_write;

    // Store data replicated over the lanes it may land in.
    always_comb begin
        case (ex_mem.funct3)
            rv_pipe_pkg::f3_byte: begin
                wr_word.word = {4{ex_mem.store_data[7:0]}};
                lane_mask = 4'b0001 << offset;
            end
            rv_pipe_pkg::f3_half: begin
                wr_word.word = {2{ex_mem.store_data[15:0]}};
                lane_mask = offset[1] ? 4'b1100 : 4'b0011;
            end
            rv_pipe_pkg::f3_word: begin
                wr_word.word = ex_mem.store_data;
                lane_mask = 4'b1111;
            end
            default: begin
                wr_word.word = ex_mem.store_data;
                lane_mask = 4'b0000;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (store_en) begin
            for (int i = 0; i < 4; i++) begin
                if (lane_mask[i]) begin
                    mem[word_idx].lanes[i] <= wr_word.lanes[i];
                end
            end
        end
    end

    assign rd_word = mem[word_idx];

    // Half lanes picked by offset bit 1; misaligned accesses fall back.
    assign byte_sel = rd_word.lanes[offset];
    assign half_sel = {rd_word.lanes[{offset[1], 1'b1}], rd_word.lanes[{offset[1], 1'b0}]};

    always_comb begin
        case (ex_mem.funct3)
            rv_pipe_pkg::f3_byte:   load_data = {{24{byte_sel[7]}}, byte_sel};
            rv_pipe_pkg::f3_half:   load_data = {{16{half_sel[15]}}, half_sel};
            rv_pipe_pkg::f3_word:   load_data = rd_word.word;
            rv_pipe_pkg::f3_byte_u: load_data = {24'h0, byte_sel};
            rv_pipe_pkg::f3_half_u: load_data = {16'h0, half_sel};
            default:                load_data = rd_word.word;
        endcase
    end

    always_comb begin
        wb.reg_write = ex_mem.valid && ex_mem.reg_write;
        wb.rd = ex_mem.rd;
        case (ex_mem.wb_sel)
            rv_pipe_pkg::wb_load: wb.data = load_data;
            rv_pipe_pkg::wb_link: wb.data = ex_mem.link;
            default:              wb.data = ex_mem.result;
        endcase
    end

    assign redirect.taken = ex_mem.valid && ex_mem.branch && ex_mem.cond_true;
    assign redirect.target = ex_mem.branch_target;

endmodule

// ==== logic/rv_pipe_pkg.sv ====
package rv_pipe_pkg;

    localparam int xlen = 32;
    localparam int mem_words = 256;
    localparam int mem_addr_bits = $clog2(mem_words);

    // Load and store widths.
    localparam logic [2:0] f3_byte = 3'b000;
    localparam logic [2:0] f3_half = 3'b001;
    localparam logic [2:0] f3_word = 3'b010;
    localparam logic [2:0] f3_byte_u = 3'b100;
    localparam logic [2:0] f3_half_u = 3'b101;

    // Branch compares.
    localparam logic [2:0] f3_beq = 3'b000;
    localparam logic [2:0] f3_bne = 3'b001;
    localparam logic [2:0] f3_blt = 3'b100;
    localparam logic [2:0] f3_bge = 3'b101;
    localparam logic [2:0] f3_bltu = 3'b110;
    localparam logic [2:0] f3_bgeu = 3'b111;

    typedef enum logic [3:0] {
        alu_add  = 4'h0,
        alu_sub  = 4'h1,
        alu_sll  = 4'h2,
        alu_slt  = 4'h3,
        alu_sltu = 4'h4,
        alu_xor  = 4'h5,
        alu_srl  = 4'h6,
        alu_sra  = 4'h7,
        alu_or   = 4'h8,
        alu_and  = 4'h9
    } alu_op_t;

    typedef enum logic [1:0] {
        res_alu   = 2'd0,
        res_auipc = 2'd1,
        res_lui   = 2'd2
    } result_sel_t;

    typedef enum logic [1:0] {
        wb_result = 2'd0,
        wb_load   = 2'd1,
        wb_link   = 2'd2
    } wb_sel_t;

    typedef struct packed {
        logic valid;
        logic branch;
        logic reg_write;
        logic mem_read;
        logic mem_write;
        wb_sel_t wb_sel;
        result_sel_t result_sel;
        alu_op_t alu_op;
        logic alu_src_imm;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [xlen-1:0] pc;
        logic [xlen-1:0] rs1_data;
        logic [xlen-1:0] rs2_data;
        logic [xlen-1:0] imm;
    } id_ex_t;

    typedef struct packed {
        logic valid;
        logic branch;
        logic reg_write;
        logic mem_read;
        logic mem_write;
        wb_sel_t wb_sel;
        logic [2:0] funct3;
        logic [4:0] rd;
        // Also the data memory address.
        logic [xlen-1:0] result;
        logic cond_true;
        logic [xlen-1:0] store_data;
        logic [xlen-1:0] branch_target;
        logic [xlen-1:0] link;
    } ex_mem_t;

    typedef struct packed {
        logic reg_write;
        logic [4:0] rd;
        logic [xlen-1:0] data;
    } wb_t;

    typedef struct packed {
        logic taken;
        logic [xlen-1:0] target;
    } redirect_t;

    // Lane 0 is the lowest address byte.
    typedef union packed {
        logic [xlen-1:0] word;
        logic [3:0][7:0] lanes;
    } mem_word_u;

endpackage

// ==== testbench/ex_mem_slice_asserts.sv ====
`timescale 1ns/10ps

module ex_mem_slice_asserts (
    input logic                   clk,
    input logic                   clear,
    input rv_pipe_pkg::id_ex_t    id_ex,
    input rv_pipe_pkg::ex_mem_t   ex_mem,
    input rv_pipe_pkg::wb_t       wb,
    input rv_pipe_pkg::redirect_t redirect
);

    int failures = 0;

    // Cleared register must look like a bubble.
    clear_quiet: assert property (
        @(posedge clk) clear |-> (!wb.reg_write && !redirect.taken)
    ) else begin
        $error("register write or redirect active while clear is high");
        failures++;
    end

    // Taken redirect comes from a valid branch issued one cycle earlier.
    taken_needs_branch: assert property (
        @(posedge clk) disable iff (clear)
        redirect.taken |-> ($past(id_ex.valid) && $past(id_ex.branch))
    ) else begin
        $error("redirect taken without a valid branch in the EX/MEM register");
        failures++;
    end

    // Load and store are exclusive.
    no_read_and_write: assert property (
        @(posedge clk) disable iff (clear)
        !(ex_mem.mem_read && ex_mem.mem_write)
    ) else begin
        $error("EX/MEM bundle has both mem_read and mem_write set");
        failures++;
    end

endmodule

bind ex_mem_slice ex_mem_slice_asserts u_asserts (
    .clk      (clk),
    .clear    (clear),
    .id_ex    (id_ex),
    .ex_mem   (ex_mem),
    .wb       (wb),
    .redirect (redirect)
);

// ==== testbench/ex_mem_slice_tb.sv ====
`timescale 1ns/10ps

module ex_mem_slice_tb;

    localparam int clk_period = 100;
    localparam int reset_cycles = 16;
    localparam int slack_cycles = 20;

    logic clk;
    logic clear;
    rv_pipe_pkg::id_ex_t id_ex;
    rv_pipe_pkg::wb_t wb;
    rv_pipe_pkg::redirect_t redirect;

    rv_pipe_pkg::id_ex_t stim_q[$];
    rv_pipe_pkg::wb_t exp_wb_q[$];
    rv_pipe_pkg::redirect_t exp_redirect_q[$];
    int test_q[$];

    int errors = 0;
    int test_errors = 0;
    int tests_passed = 0;
    int tests_failed = 0;
    logic trace_loaded = 1'b0;

    ex_mem_slice DUT (
        .clk      (clk),
        .clear    (clear),
        .id_ex    (id_ex),
        .wb       (wb),
        .redirect (redirect)
    );

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    task automatic report_mismatch(input string name, input logic [31:0] expected,
                                   input logic [31:0] actual);
        $display("mismatch at time %0d ns: %s expected %h, got %h",
                 $time, name, expected, actual);
        errors++;
        test_errors++;
    endtask

    task automatic finish_test(input int id);
        if (test_errors == 0) begin
            tests_passed++;
            $display("test %0d passed", id);
        end else begin
            tests_failed++;
            $display("test %0d failed with %0d mismatches", id, test_errors);
        end
        test_errors = 0;
    endtask

    // Columns are described at the top of the trace file.
    task automatic read_trace(output bit ok);
        int fd;
        int n;
        string line;
        logic [31:0] f [21];
        rv_pipe_pkg::id_ex_t s;
        rv_pipe_pkg::wb_t w;
        rv_pipe_pkg::redirect_t r;
        ok = 1'b0;
        fd = $fopen("testbench/ex_mem_trace.txt", "r");
        if (fd == 0) begin
            $display("error: cannot open the trace file testbench/ex_mem_trace.txt");
            return;
        end
        while (!$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            if (line.len() < 2 || line[0] == "#") begin
                continue;
            end
            n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                        f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8], f[9], f[10],
                        f[11], f[12], f[13], f[14], f[15], f[16], f[17], f[18], f[19], f[20]);
            if (n != 21) begin
                $display("error: trace line could not be read: %s", line);
                $fclose(fd);
                return;
            end
            s = '0;
            s.valid = f[1][0];
            s.branch = f[2][0];
            s.reg_write = f[3][0];
            s.mem_read = f[4][0];
            s.mem_write = f[5][0];
            s.wb_sel = rv_pipe_pkg::wb_sel_t'(f[6][1:0]);
            s.result_sel = rv_pipe_pkg::result_sel_t'(f[7][1:0]);
            s.alu_op = rv_pipe_pkg::alu_op_t'(f[8][3:0]);
            s.alu_src_imm = f[9][0];
            s.funct3 = f[10][2:0];
            s.rd = f[11][4:0];
            s.pc = f[12];
            s.rs1_data = f[13];
            s.rs2_data = f[14];
            s.imm = f[15];
            w.reg_write = f[16][0];
            w.rd = f[17][4:0];
            w.data = f[18];
            r.taken = f[19][0];
            r.target = f[20];
            test_q.push_back(int'(f[0]));
            stim_q.push_back(s);
            exp_wb_q.push_back(w);
            exp_redirect_q.push_back(r);
        end
        $fclose(fd);
        ok = (stim_q.size() > 0);
        if (!ok) begin
            $display("error: the trace file holds no instructions");
        end
    endtask

    task automatic check_outputs(input int idx);
        rv_pipe_pkg::wb_t ew;
        rv_pipe_pkg::redirect_t er;
        ew = exp_wb_q[idx];
        er = exp_redirect_q[idx];
        if (wb.reg_write !== ew.reg_write) begin
            report_mismatch("wb.reg_write", ew.reg_write, wb.reg_write);
        end
        // Data and rd only matter for a register write.
        if (ew.reg_write && wb.rd !== ew.rd) begin
            report_mismatch("wb.rd", ew.rd, wb.rd);
        end
        if (ew.reg_write && wb.data !== ew.data) begin
            report_mismatch("wb.data", ew.data, wb.data);
        end
        if (redirect.taken !== er.taken) begin
            report_mismatch("redirect.taken", er.taken, redirect.taken);
        end
        if (er.taken && redirect.target !== er.target) begin
            report_mismatch("redirect.target", er.target, redirect.target);
        end
    endtask

    initial begin
        bit ok;
        int n;
        rv_pipe_pkg::id_ex_t busy;
        clear = 1'b0;
        id_ex = '0;
        read_trace(ok);
        #1;
        clear = 1'b1;
        if (!ok) begin
            errors++;
        end else begin
            trace_loaded = 1'b1;
            n = stim_q.size();
            // Valid write and taken branch, which clear must hide.
            busy = '0;
            busy.valid = 1'b1;
            busy.branch = 1'b1;
            busy.reg_write = 1'b1;
            busy.rd = 5'd1;
            for (int c = 0; c < reset_cycles; c++) begin
                @(posedge clk);
                id_ex <= busy;
                @(negedge clk);
                if (wb.reg_write !== 1'b0) begin
                    report_mismatch("wb.reg_write", 32'd0, wb.reg_write);
                end
                if (redirect.taken !== 1'b0) begin
                    report_mismatch("redirect.taken", 32'd0, redirect.taken);
                end
            end
            finish_test(0);
            for (int i = 0; i <= n; i++) begin
                @(posedge clk);
                clear <= 1'b0;
                if (i < n) begin
                    id_ex <= stim_q[i];
                end else begin
                    id_ex <= '0;
                end
                @(negedge clk);
                if (i > 0) begin
                    check_outputs(i - 1);
                    if (i == n || test_q[i] != test_q[i - 1]) begin
                        finish_test(test_q[i - 1]);
                    end
                end
            end
        end
        if (DUT.u_asserts.failures != 0) begin
            $display("error: %0d assertion failures were reported during the run",
                     DUT.u_asserts.failures);
            errors += DUT.u_asserts.failures;
        end
        $display("summary: %0d tests passed, %0d tests failed, %0d mismatches",
                 tests_passed, tests_failed, errors);
        if (errors == 0 && tests_failed == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

    initial begin
        wait (trace_loaded === 1'b1);
        #((reset_cycles + stim_q.size() + slack_cycles) * clk_period);
        $display("timeout: the run did not finish within the expected number of cycles");
        $display("ERRORS FOUND");
        $finish;
    end

endmodule

// ==== testbench/ex_mem_trace.txt ====
# test valid branch reg_write mem_read mem_write wb_sel result_sel alu_op imm funct3 rd pc rs1 rs2 imm
# then expected: reg_write rd data taken target (all hex)
1 1 0 1 0 0 0 0 0 0 0 01 00000100 00000005 00000003 00000000 1 01 00000008 0 00000000
1 1 0 1 0 0 0 0 0 1 0 02 00000104 00000010 12345678 ffffffff 1 02 0000000f 0 00000000
1 1 0 1 0 0 0 0 1 0 0 03 00000108 00000003 00000005 00000000 1 03 fffffffe 0 00000000
1 1 0 1 0 0 0 0 2 0 0 04 0000010c 00000001 00000024 00000000 1 04 00000010 0 00000000
1 1 0 1 0 0 0 0 3 0 0 05 00000110 ffffffff 00000001 00000000 1 05 00000001 0 00000000
1 1 0 1 0 0 0 0 4 0 0 06 00000114 ffffffff 00000001 00000000 1 06 00000000 0 00000000
1 1 0 1 0 0 0 0 3 1 0 07 00000118 00000001 00000000 ffffffff 1 07 00000000 0 00000000
1 1 0 1 0 0 0 0 4 1 0 08 0000011c 00000001 00000000 ffffffff 1 08 00000001 0 00000000
1 1 0 1 0 0 0 0 5 1 0 09 00000120 f0f0f0f0 00000000 ffffffff 1 09 0f0f0f0f 0 00000000
1 1 0 1 0 0 0 0 6 1 0 0a 00000124 80000000 00000000 00000004 1 0a 08000000 0 00000000
1 1 0 1 0 0 0 0 7 1 0 0b 00000128 80000000 00000000 00000004 1 0b f8000000 0 00000000
1 1 0 1 0 0 0 0 7 0 0 0c 0000012c 70000000 00000008 00000000 1 0c 00700000 0 00000000
1 1 0 1 0 0 0 0 8 0 0 0d 00000130 00ff0000 0000ff00 00000000 1 0d 00ffff00 0 00000000
1 1 0 1 0 0 0 0 9 1 0 0e 00000134 12345678 00000000 00000ff0 1 0e 00000670 0 00000000
2 1 0 1 0 0 0 1 0 0 0 01 00000200 00000000 00000000 00012000 1 01 00012200 0 00000000
2 1 0 1 0 0 0 2 0 0 0 02 00000204 11111111 00000000 abcde000 1 02 abcde000 0 00000000
2 1 1 1 0 0 2 0 0 1 0 01 00000300 00000000 00000000 00000040 1 01 00000304 1 00000340
2 1 0 1 0 0 2 0 0 1 0 03 fffffffc 00000000 00000000 00000008 1 03 00000000 0 00000000
3 1 0 0 0 1 0 0 0 1 2 00 00000400 00000040 80ff7f01 00000000 0 00 00000000 0 00000000
3 1 0 1 1 0 1 0 0 1 2 05 00000404 00000040 00000000 00000000 1 05 80ff7f01 0 00000000
3 1 0 1 1 0 1 0 0 1 0 06 00000408 0000003c 00000000 00000004 1 06 00000001 0 00000000
3 1 0 1 1 0 1 0 0 1 0 07 0000040c 00000040 00000000 00000003 1 07 ffffff80 0 00000000
3 1 0 1 1 0 1 0 0 1 4 08 00000410 00000040 00000000 00000003 1 08 00000080 0 00000000
3 1 0 1 1 0 1 0 0 1 0 09 00000414 00000042 00000000 00000000 1 09 ffffffff 0 00000000
3 1 0 1 1 0 1 0 0 1 1 0a 00000418 00000042 00000000 00000000 1 0a ffff80ff 0 00000000
3 1 0 1 1 0 1 0 0 1 5 0b 0000041c 00000042 00000000 00000000 1 0b 000080ff 0 00000000
3 1 0 1 1 0 1 0 0 1 1 0c 00000420 00000040 00000000 00000000 1 0c 00007f01 0 00000000
3 1 0 0 0 1 0 0 0 1 1 00 00000424 00000044 1234beef 00000002 0 00 00000000 0 00000000
3 1 0 0 0 1 0 0 0 1 0 00 00000428 00000048 000000a5 fffffffd 0 00 00000000 0 00000000
3 1 0 0 0 1 0 0 0 1 0 00 0000042c 00000044 ffffff5a 00000000 0 00 00000000 0 00000000
3 1 0 1 1 0 1 0 0 1 2 0d 00000430 00000044 00000000 00000000 1 0d beefa55a 0 00000000
3 1 0 0 0 1 0 0 0 1 1 00 00000434 00000040 0000cafe 00000000 0 00 00000000 0 00000000
3 1 0 1 1 0 1 0 0 1 2 0e 00000438 00000040 00000000 00000000 1 0e 80ffcafe 0 00000000
3 1 0 1 1 0 1 0 0 1 5 0f 0000043c 00000046 00000000 00000000 1 0f 0000beef 0 00000000
3 1 0 1 1 0 1 0 0 1 1 10 00000440 00000046 00000000 00000000 1 10 ffffbeef 0 00000000
3 1 0 0 0 1 0 0 0 1 2 00 00000444 000003fc deadbeef 00000000 0 00 00000000 0 00000000
3 1 0 1 1 0 1 0 0 1 2 11 00000448 000003fc 00000000 00000000 1 11 deadbeef 0 00000000
4 1 1 0 0 0 0 0 0 0 0 00 00000500 00000007 00000007 00000010 0 00 00000000 1 00000510
4 1 1 0 0 0 0 0 0 0 0 00 00000504 00000007 00000008 00000010 0 00 00000000 0 00000000
4 1 1 0 0 0 0 0 0 0 1 00 00000508 00000007 00000008 fffffff0 0 00 00000000 1 000004f8
4 1 1 0 0 0 0 0 0 0 1 00 0000050c 00000007 00000007 fffffff0 0 00 00000000 0 00000000
4 1 1 0 0 0 0 0 0 0 4 00 00000510 ffffffff 00000001 00000100 0 00 00000000 1 00000610
4 1 1 0 0 0 0 0 0 0 4 00 00000514 00000001 ffffffff 00000100 0 00 00000000 0 00000000
4 1 1 0 0 0 0 0 0 0 5 00 00000518 00000001 ffffffff 00000020 0 00 00000000 1 00000538
4 1 1 0 0 0 0 0 0 0 5 00 0000051c ffffffff 00000001 00000020 0 00 00000000 0 00000000
4 1 1 0 0 0 0 0 0 0 5 00 00000520 00000005 00000005 00000008 0 00 00000000 1 00000528
4 1 1 0 0 0 0 0 0 0 6 00 00000524 00000001 ffffffff 00000008 0 00 00000000 1 0000052c
4 1 1 0 0 0 0 0 0 0 6 00 00000528 ffffffff 00000001 00000008 0 00 00000000 0 00000000
4 1 1 0 0 0 0 0 0 0 7 00 0000052c ffffffff 00000001 00000004 0 00 00000000 1 00000530
4 1 1 0 0 0 0 0 0 0 7 00 00000530 00000001 ffffffff 00000004 0 00 00000000 0 00000000
5 0 0 1 0 0 0 0 0 0 0 03 00000600 00000001 00000002 00000000 0 00 00000000 0 00000000
5 0 1 0 0 0 0 0 0 0 0 00 00000604 00000000 00000000 00000040 0 00 00000000 0 00000000
5 0 0 0 0 1 0 0 0 1 2 00 00000608 00000044 00000000 00000000 0 00 00000000 0 00000000
5 1 0 1 1 0 1 0 0 1 2 12 0000060c 00000044 00000000 00000000 1 12 beefa55a 0 00000000
